// File: all.f
verilog/aes_pkg.sv
verilog/block_ram.sv
verilog/aes_axis_slave.sv
verilog/aes_feeder.sv
verilog/aes_round_stage.sv
verilog/aes_axis_master.sv
verilog/aes_top.sv
sim/tb_aes_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_aes_top -f all.f -o sim_aes
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_aes 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

// File: sim/tb_aes_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aes_top import aes_pkg::*; ();

	localparam key_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t PT_A = 128'h00112233445566778899aabbccddeeff;
	localparam block_t CT_A = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam key_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t PT_B = 128'h3243f6a8885a308d313198a2e0370734;
	localparam block_t CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam int TIMEOUT_CYCLES = 1000;
	localparam int QUIET_CYCLES = 24;

	logic s00_axis_aclk;
	logic rst;
	logic s00_axis_tvalid;
	logic s00_axis_tready;
	word_t s00_axis_tdata;
	logic s00_axis_tlast;
	logic m00_axis_tvalid;
	logic m00_axis_tready;
	block_t m00_axis_tdata;
	logic m00_axis_tlast;

	integer seed;
	int error_count;
	int test_count;
	int failed_count;
	logic gaps_on;
	logic backpressure_on;
	logic first_sent;

	// Plaintexts to send, and what must come back for each
	block_t tx_blocks[$];
	block_t exp_data[$];
	logic exp_known[$];
	logic exp_last[$];

	aes_top aes_top_i (
		.s00_axis_aclk(s00_axis_aclk),
		.rst(rst),
		.s00_axis_tvalid(s00_axis_tvalid),
		.s00_axis_tready(s00_axis_tready),
		.s00_axis_tdata(s00_axis_tdata),
		.s00_axis_tlast(s00_axis_tlast),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tready(m00_axis_tready),
		.m00_axis_tdata(m00_axis_tdata),
		.m00_axis_tlast(m00_axis_tlast)
	);

	always #20 s00_axis_aclk = ~s00_axis_aclk;

	task abort_run(input string why);
		$display("%s, at %0t", why, $time);
		$display("Test FAILED");
		$finish;
	endtask

	task compare_block(input string name, input block_t expected, input block_t actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task compare_last(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Called on a falling edge and returns on the falling edge after the transfer
	task send_word(input word_t data, input logic last);
		int wait_cnt;
		logic [31:0] rnd;
		if (gaps_on) begin
			rnd = $random(seed);
			repeat (int'(rnd[1:0])) @(negedge s00_axis_aclk);
		end
		s00_axis_tvalid = 1'b1;
		s00_axis_tdata = data;
		s00_axis_tlast = last;
		wait_cnt = 0;
		while (!s00_axis_tready) begin
			@(negedge s00_axis_aclk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT_CYCLES) begin
				abort_run("Input stream never became ready");
			end
		end
		@(negedge s00_axis_aclk);
		s00_axis_tvalid = 1'b0;
		s00_axis_tlast = 1'b0;
	endtask

	task send_key(input key_t key);
		send_word(CMD_KEY, 1'b0);
		for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
			send_word(key[127 - 32 * i -: 32], i == WORDS_PER_BLOCK - 1);
		end
	endtask

	// Sends tx_blocks as one packet with the top 32 bits of each block first
	task send_blocks();
		send_word(CMD_ENCRYPT, 1'b0);
		for (int b = 0; b < tx_blocks.size(); b++) begin
			for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
				send_word(tx_blocks[b][127 - 32 * i -: 32],
					b == tx_blocks.size() - 1 && i == WORDS_PER_BLOCK - 1);
			end
			first_sent = 1'b1;
		end
	endtask

	task collect_results();
		int idle_cnt;
		logic [31:0] rnd;
		logic ready;
		block_t want;
		logic want_last;
		logic known;
		idle_cnt = 0;
		while (exp_data.size() != 0) begin
			@(negedge s00_axis_aclk);
			rnd = $random(seed);
			ready = backpressure_on ? (rnd[1:0] != 2'b00) : 1'b1;
			m00_axis_tready = ready;
			if (m00_axis_tvalid && ready) begin
				if (!first_sent) begin
					$display("Result appeared before the first block was sent, at %0t", $time);
					error_count++;
				end
				want = exp_data.pop_front();
				want_last = exp_last.pop_front();
				known = exp_known.pop_front();
				if (known) begin
					compare_block("m00_axis_tdata", want, m00_axis_tdata);
				end
				compare_last("m00_axis_tlast", want_last, m00_axis_tlast);
				idle_cnt = 0;
			end else begin
				idle_cnt++;
				if (idle_cnt > TIMEOUT_CYCLES) begin
					abort_run("Expected result did not arrive on the output stream");
				end
			end
		end
	endtask

	// Nothing more may come out once every expected block is seen
	task check_quiet();
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge s00_axis_aclk);
			m00_axis_tready = 1'b1;
			if (m00_axis_tvalid) begin
				$display("Extra result on the output stream, at %0t", $time);
				error_count++;
			end
		end
	endtask

	task add_block(input block_t pt, input block_t ct, input logic known, input logic last);
		tx_blocks.push_back(pt);
		exp_data.push_back(ct);
		exp_known.push_back(known);
		exp_last.push_back(last);
	endtask

	task run_encrypt();
		first_sent = 1'b0;
		fork
			send_blocks();
			collect_results();
		join
		check_quiet();
		tx_blocks.delete();
	endtask

	task report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("%-32s passed", name);
		end else begin
			failed_count++;
			$display("%-32s failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task test_single_block(input string name, input key_t key, input block_t pt,
		input block_t ct);
		int errors_before;
		errors_before = error_count;
		send_key(key);
		add_block(pt, ct, 1'b1, 1'b1);
		run_encrypt();
		report_test(name, errors_before);
	endtask

	task test_three_blocks();
		int errors_before;
		errors_before = error_count;
		// Key B is still loaded and PT_A has no known answer under it
		add_block(PT_B, CT_B, 1'b1, 1'b0);
		add_block(PT_A, '0, 1'b0, 1'b0);
		add_block(PT_B, CT_B, 1'b1, 1'b1);
		run_encrypt();
		report_test("three block packet", errors_before);
	endtask

	task test_two_batches();
		int errors_before;
		errors_before = error_count;
		send_key(KEY_A);
		for (int i = 0; i < 20; i++) begin
			add_block(PT_A, CT_A, 1'b1, i == 19);
		end
		backpressure_on = 1'b1;
		run_encrypt();
		backpressure_on = 1'b0;
		report_test("two batches, back-pressure", errors_before);
	endtask

	task test_input_gaps();
		int errors_before;
		errors_before = error_count;
		// Key A is still loaded, so every result has a known answer
		for (int i = 0; i < 5; i++) begin
			add_block(PT_A, CT_A, 1'b1, i == 4);
		end
		gaps_on = 1'b1;
		run_encrypt();
		gaps_on = 1'b0;
		report_test("five blocks, input gaps", errors_before);
	endtask

	initial begin
		seed = 32'h576e14f4;
		s00_axis_aclk = 1'b0;
		rst = 1'b1;
		s00_axis_tvalid = 1'b0;
		s00_axis_tdata = '0;
		s00_axis_tlast = 1'b0;
		m00_axis_tready = 1'b0;
		error_count = 0;
		test_count = 0;
		failed_count = 0;
		gaps_on = 1'b0;
		backpressure_on = 1'b0;
		first_sent = 1'b0;
		repeat (10) @(posedge s00_axis_aclk);
		@(negedge s00_axis_aclk);
		rst = 1'b0;
		@(negedge s00_axis_aclk);

		test_single_block("known answer, key A", KEY_A, PT_A, CT_A);
		test_single_block("known answer, key B", KEY_B, PT_B, CT_B);
		test_three_blocks();
		test_two_batches();
		test_input_gaps();

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/aes_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_top import aes_pkg::*; (
	input logic s00_axis_aclk,
	input logic rst,
	input logic s00_axis_tvalid,
	output logic s00_axis_tready,
	input word_t s00_axis_tdata,
	input logic s00_axis_tlast,
	output logic m00_axis_tvalid,
	input logic m00_axis_tready,
	output block_t m00_axis_tdata,
	output logic m00_axis_tlast
);

	logic writes_done;
	logic processing_done;
	blk_cnt_t blk_cnt;
	logic batch_last;
	key_t cipher_key;
	buf_addr_t buf_addr;
	logic buf_wr_en;
	block_t buf_wr_data;
	logic rd_en;
	buf_addr_t rd_addr;
	buf_addr_t ram_addr;
	block_t rd_data;
	logic credit_return;
	// Slot 0 from the feeder, slot NUM_ROUNDS into the master
	aes_stage_s stage [0:NUM_ROUNDS];

	// Slave and feeder never use the buffer at the same time
	assign ram_addr = rd_en ? rd_addr : buf_addr;

	aes_axis_slave slave_i (
		.s00_axis_aclk(s00_axis_aclk),
		.rst(rst),
		.s00_axis_tvalid(s00_axis_tvalid),
		.s00_axis_tready(s00_axis_tready),
		.s00_axis_tdata(s00_axis_tdata),
		.s00_axis_tlast(s00_axis_tlast),
		.processing_done(processing_done),
		.writes_done(writes_done),
		.blk_cnt(blk_cnt),
		.batch_last(batch_last),
		.cipher_key(cipher_key),
		.buf_addr(buf_addr),
		.buf_wr_en(buf_wr_en),
		.buf_wr_data(buf_wr_data)
	);

	block_ram ram_i (
		.clk(s00_axis_aclk),
		.addr(ram_addr),
		.wr_en(buf_wr_en),
		.wr_data(buf_wr_data),
		.rd_en(rd_en),
		.rd_data(rd_data)
	);

	aes_feeder feeder_i (
		.s00_axis_aclk(s00_axis_aclk),
		.rst(rst),
		.writes_done(writes_done),
		.blk_cnt(blk_cnt),
		.batch_last(batch_last),
		.processing_done(processing_done),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.cipher_key(cipher_key),
		.credit_return(credit_return),
		.stage_out(stage[0])
	);

	for (genvar i = 1; i <= NUM_ROUNDS; i++) begin : g_round
		aes_round_stage #(
			.ROUND(i)
		) round_i (
			.s00_axis_aclk(s00_axis_aclk),
			.rst(rst),
			.stage_in(stage[i - 1]),
			.stage_out(stage[i])
		);
	end

	aes_axis_master master_i (
		.s00_axis_aclk(s00_axis_aclk),
		.rst(rst),
		.stage_in(stage[NUM_ROUNDS]),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tready(m00_axis_tready),
		.m00_axis_tdata(m00_axis_tdata),
		.m00_axis_tlast(m00_axis_tlast),
		.credit_return(credit_return)
	);

endmodule

`default_nettype wire

// File: verilog/aes_axis_master.sv
`timescale 1ns/100ps
`default_nettype none

module aes_axis_master import aes_pkg::*; (
	input logic s00_axis_aclk,
	input logic rst,
	input aes_stage_s stage_in,
	output logic m00_axis_tvalid,
	input logic m00_axis_tready,
	output block_t m00_axis_tdata,
	output logic m00_axis_tlast,
	output logic credit_return
);

	block_t q_data [OUT_DEPTH];
	logic q_last [OUT_DEPTH];
	out_addr_t wr_ptr;
	out_addr_t rd_ptr;
	credit_t count;
	logic push;
	logic pop;
	logic full;

	assign push = stage_in.valid;
	assign pop = m00_axis_tvalid && m00_axis_tready;
	assign full = (count == credit_t'(OUT_DEPTH));

	// Head of the queue drives the bus directly
	assign m00_axis_tvalid = (count != '0);
	assign m00_axis_tdata = q_data[rd_ptr];
	assign m00_axis_tlast = q_last[rd_ptr];
	assign credit_return = pop;

	always_ff @(posedge s00_axis_aclk) begin
		if (push) begin
			q_data[wr_ptr] <= stage_in.state;
			q_last[wr_ptr] <= stage_in.last;
		end
	end

	always_ff @(posedge s00_axis_aclk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + out_addr_t'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + out_addr_t'(1);
			end
			case ({push, pop})
				2'b10: count <= count + credit_t'(1);
				2'b01: count <= count - credit_t'(1);
				default: count <= count;
			endcase
		end
	end

	// Feeder credits must keep the pipeline from overrunning the queue
	a_no_push_when_full: assert property (@(posedge s00_axis_aclk) disable iff (rst)
		stage_in.valid |-> !full);

endmodule

`default_nettype wire

// File: verilog/aes_round_stage.sv
`timescale 1ns/100ps
`default_nettype none

module aes_round_stage import aes_pkg::*; #(
	parameter int ROUND = 1
) (
	input logic s00_axis_aclk,
	input logic rst,
	input aes_stage_s stage_in,
	output aes_stage_s stage_out
);

	word_t rot_sub;
	key_t next_key;
	block_t sub;
	block_t shifted;
	block_t mixed;

	function automatic word_t mix_column(input word_t col);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// Key schedule for this round, from the previous round key
	always_comb begin
		rot_sub = {sbox(stage_in.round_key[23:16]), sbox(stage_in.round_key[15:8]),
			sbox(stage_in.round_key[7:0]), sbox(stage_in.round_key[31:24])}
			^ {rcon_of(ROUND), 24'h000000};
		next_key[127:96] = stage_in.round_key[127:96] ^ rot_sub;
		next_key[95:64] = stage_in.round_key[95:64] ^ next_key[127:96];
		next_key[63:32] = stage_in.round_key[63:32] ^ next_key[95:64];
		next_key[31:0] = stage_in.round_key[31:0] ^ next_key[63:32];
	end

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			sub[127 - 8 * i -: 8] = sbox(stage_in.state[127 - 8 * i -: 8]);
		end
		// Row r rotates left by r columns
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127 - 8 * (4 * c + r) -: 8] = sub[127 - 8 * (4 * ((c + r) % 4) + r) -: 8];
			end
		end
		// No MixColumns in the last round
		if (ROUND == NUM_ROUNDS) begin
			mixed = shifted;
		end else begin
			for (int c = 0; c < 4; c++) begin
				mixed[127 - 32 * c -: 32] = mix_column(shifted[127 - 32 * c -: 32]);
			end
		end
	end

	always_ff @(posedge s00_axis_aclk) begin
		stage_out.last <= stage_in.last;
		stage_out.state <= mixed ^ next_key;
		stage_out.round_key <= next_key;
		if (rst) begin
			stage_out.valid <= 1'b0;
		end else begin
			stage_out.valid <= stage_in.valid;
		end
	end

endmodule

`default_nettype wire

// File: verilog/aes_feeder.sv
`timescale 1ns/100ps
`default_nettype none

module aes_feeder import aes_pkg::*; (
	input logic s00_axis_aclk,
	input logic rst,
	input logic writes_done,
	input blk_cnt_t blk_cnt,
	input logic batch_last,
	output logic processing_done,
	output logic rd_en,
	output buf_addr_t rd_addr,
	input block_t rd_data,
	input key_t cipher_key,
	input logic credit_return,
	output aes_stage_s stage_out
);

	feeder_state_e state;
	blk_cnt_t rd_cnt;
	credit_t credits;
	logic last_rd;
	logic valid_d1;
	logic last_d1;

	assign rd_en = (state == READ) && (credits != '0);
	assign rd_addr = rd_cnt[3:0];
	assign last_rd = (rd_cnt == blk_cnt - blk_cnt_t'(1));
	assign processing_done = (state == DONE);

	always_ff @(posedge s00_axis_aclk) begin
		if (rst) begin
			state <= IDLE;
			rd_cnt <= '0;
			credits <= credit_t'(OUT_DEPTH);
		end else begin
			case (state)
				IDLE: begin
					rd_cnt <= '0;
					if (writes_done) begin
						state <= READ;
					end
				end
				READ: begin
					if (rd_en) begin
						rd_cnt <= rd_cnt + blk_cnt_t'(1);
						if (last_rd) begin
							state <= DONE;
						end
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
			// Spend on read issue, refill on output transfer
			case ({rd_en, credit_return})
				2'b10: credits <= credits - credit_t'(1);
				2'b01: credits <= credits + credit_t'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Round 0 key addition as the block comes back from the buffer
	always_ff @(posedge s00_axis_aclk) begin
		last_d1 <= rd_en && last_rd && batch_last;
		stage_out.last <= last_d1;
		stage_out.state <= rd_data ^ cipher_key;
		stage_out.round_key <= cipher_key;
		if (rst) begin
			valid_d1 <= 1'b0;
			stage_out.valid <= 1'b0;
		end else begin
			valid_d1 <= rd_en;
			stage_out.valid <= valid_d1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/aes_axis_slave.sv
`timescale 1ns/100ps
`default_nettype none

module aes_axis_slave import aes_pkg::*; (
	input logic s00_axis_aclk,
	input logic rst,
	input logic s00_axis_tvalid,
	output logic s00_axis_tready,
	input word_t s00_axis_tdata,
	input logic s00_axis_tlast,
	input logic processing_done,
	output logic writes_done,
	output blk_cnt_t blk_cnt,
	output logic batch_last,
	output key_t cipher_key,
	output buf_addr_t buf_addr,
	output logic buf_wr_en,
	output block_t buf_wr_data
);

	slave_state_e state;
	logic [1:0] word_cnt;
	blk_cnt_t wr_cnt;
	logic close_pending;
	logic accept;
	logic block_full;

	// Stall while a closed batch waits for the feeder
	assign s00_axis_tready = !writes_done && !close_pending;
	assign accept = s00_axis_tvalid && s00_axis_tready;
	assign block_full = (word_cnt == 2'(WORDS_PER_BLOCK - 1));

	always_ff @(posedge s00_axis_aclk) begin
		if (rst) begin
			state <= GET_CMD;
			word_cnt <= '0;
			wr_cnt <= '0;
			buf_wr_en <= 1'b0;
			close_pending <= 1'b0;
			writes_done <= 1'b0;
			blk_cnt <= '0;
			batch_last <= 1'b0;
		end else begin
			buf_wr_en <= 1'b0;
			close_pending <= 1'b0;
			// Batch handed over on the edge of its final write
			if (close_pending) begin
				writes_done <= 1'b1;
			end
			case (state)
				GET_CMD: begin
					word_cnt <= '0;
					if (accept) begin
						if (s00_axis_tdata == CMD_KEY) begin
							state <= GET_KEY;
						end else if (s00_axis_tdata == CMD_ENCRYPT) begin
							state <= GET_PAYLOAD;
						end
					end
				end
				GET_KEY: begin
					if (accept) begin
						word_cnt <= word_cnt + 2'd1;
						if (block_full) begin
							state <= GET_CMD;
						end
					end
				end
				GET_PAYLOAD: begin
					if (accept) begin
						word_cnt <= word_cnt + 2'd1;
						if (block_full) begin
							buf_wr_en <= 1'b1;
							wr_cnt <= wr_cnt + blk_cnt_t'(1);
							// Buffer full or end of packet
							if (wr_cnt == blk_cnt_t'(BUF_DEPTH - 1) || s00_axis_tlast) begin
								close_pending <= 1'b1;
								blk_cnt <= wr_cnt + blk_cnt_t'(1);
								batch_last <= s00_axis_tlast;
								wr_cnt <= '0;
							end
						end
					end
					if (processing_done) begin
						writes_done <= 1'b0;
						if (batch_last) begin
							state <= GET_CMD;
						end
					end
				end
				default: state <= GET_CMD;
			endcase
		end
	end

	// Key and block shift registers, first word lands in the top bits
	always_ff @(posedge s00_axis_aclk) begin
		if (accept && state == GET_KEY) begin
			cipher_key <= {cipher_key[95:0], s00_axis_tdata};
		end
		if (accept && state == GET_PAYLOAD) begin
			buf_wr_data <= {buf_wr_data[95:0], s00_axis_tdata};
			if (block_full) begin
				buf_addr <= wr_cnt[3:0];
			end
		end
	end

	a_no_write_in_batch: assert property (@(posedge s00_axis_aclk) disable iff (rst)
		writes_done |-> !buf_wr_en);

	// Feeder only finishes a batch the slave has handed over
	a_done_needs_batch: assert property (@(posedge s00_axis_aclk) disable iff (rst)
		processing_done |-> writes_done);

endmodule

`default_nettype wire

// File: verilog/block_ram.sv
`timescale 1ns/100ps
`default_nettype none

module block_ram import aes_pkg::*; (
	input logic clk,
	input buf_addr_t addr,
	input logic wr_en,
	input block_t wr_data,
	input logic rd_en,
	output block_t rd_data
);

	block_t mem [BUF_DEPTH];

	// Registered read, data valid the cycle after rd_en
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[addr] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: verilog/aes_pkg.sv
`default_nettype none

package aes_pkg;

	localparam int BUF_DEPTH = 16;
	localparam int OUT_DEPTH = 16;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int NUM_ROUNDS = 10;

	typedef logic [31:0] word_t;
	typedef logic [127:0] block_t;
	typedef logic [127:0] key_t;
	typedef logic [3:0] buf_addr_t;
	typedef logic [4:0] blk_cnt_t;
	typedef logic [4:0] credit_t;
	typedef logic [3:0] out_addr_t;

	localparam word_t CMD_KEY = 32'd1;
	localparam word_t CMD_ENCRYPT = 32'd2;

	// One pipeline slot, from the feeder through the rounds to the master
	typedef struct packed {
		logic valid;
		logic last;
		block_t state;
		key_t round_key;
	} aes_stage_s;

	typedef enum logic [1:0] {
		GET_CMD,
		GET_KEY,
		GET_PAYLOAD
	} slave_state_e;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		DONE
	} feeder_state_e;

	// Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] t;
		p = 8'h00;
		t = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				p = p ^ t;
			end
			t = xtime(t);
		end
		return p;
	endfunction

	// Inverse as a^254, then the affine map
	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] sq;
		logic [7:0] inv;
		sq = a;
		inv = 8'h01;
		// a^2 * a^4 * ... * a^128
		for (int i = 1; i < 8; i++) begin
			sq = gf_mul(sq, sq);
			inv = gf_mul(inv, sq);
		end
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
			^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
	endfunction

	// Round constant for key expansion, rounds 1 to 10
	function automatic logic [7:0] rcon_of(input int round);
		logic [7:0] r;
		r = 8'h01;
		for (int i = 1; i < NUM_ROUNDS; i++) begin
			if (i < round) begin
				r = xtime(r);
			end
		end
		return r;
	endfunction

endpackage

`default_nettype wire
